// File: Bender.yml
package:
  name: scope_capture

sources:
  - rtl/scope_pkg.sv
  - rtl/scope_cfg_if.sv
  - rtl/scope_ctrl.sv
  - rtl/scope_dec_avg.sv
  - rtl/scope_edge.sv
  - rtl/scope_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_scope.sv

// File: rtl/scope_cfg_if.sv
//////////////////////////////////////////////////
// scope configuration bundle
// register values from control to datapath
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface scope_cfg_if #(
  int unsigned DWI = 14,  // sample width
  int unsigned DWC = 17,  // decimation counter width
  int unsigned DWS = 4    // shift width
);

  logic                  clr;  // one cycle flush pulse
  logic                  avg;  // averaging on
  logic        [DWC-1:0] dec;  // group length minus one
  logic        [DWS-1:0] shr;  // sum shift right
  logic signed [DWI-1:0] lvl;  // edge level
  logic        [DWI-1:0] hst;  // hysteresis, magnitude only

  // register bank side
  modport ctrl (output clr, avg, dec, shr, lvl, hst);

  // decimator side
  modport decim (input clr, avg, dec, shr);

  // level crossing detector side
  modport edge_det (input lvl, hst);

endinterface : scope_cfg_if

// File: rtl/scope_ctrl.sv
//////////////////////////////////////////////////
// scope control
// register bank, trigger select, arm/trigger/delay
// sequencing and the output stream stage
//////////////////////////////////////////////////

`timescale 1ns/100ps

module scope_ctrl
  import scope_pkg::*;
#(
  int unsigned DWI = 14,  // sample width
  int unsigned DWC = 17,  // decimation counter width
  int unsigned DWS = 4,   // shift width
  int unsigned TWA = 4,   // external trigger lines
  int unsigned TWS = 2    // trigger select width
)(
  input  logic                  clk,
  input  logic                  rstn,
  // system bus
  input  logic           [31:0] sys_addr,
  input  logic           [31:0] sys_wdata,
  input  logic            [3:0] sys_sel,
  input  logic                  sys_wen,
  input  logic                  sys_ren,
  output logic           [31:0] sys_rdata,
  output logic                  sys_err,
  output logic                  sys_ack,
  // triggers
  input  logic        [TWA-1:0] trg_ext,
  output logic                  trg_swo,
  // datapath config
  scope_cfg_if.ctrl             cfg,
  // decimated stream in
  input  logic signed [DWI-1:0] std_dat,
  input  logic                  std_vld,
  output logic                  std_rdy,
  // captured stream out
  output logic signed [DWI-1:0] sto_dat,
  output logic                  sto_vld,
  output logic                  sto_lst,
  input  logic                  sto_rdy
);

  // config registers
  logic                  cfg_avg;
  logic        [DWC-1:0] cfg_dec;
  logic        [DWS-1:0] cfg_shr;
  logic signed [DWI-1:0] cfg_lvl;
  logic        [DWI-1:0] cfg_hst;
  logic        [TWS-1:0] cfg_sel;
  logic           [31:0] cfg_dly;

  // bus decode
  logic           [31:0] wr_mask;   // byte lanes from sys_sel
  logic           [31:0] rd_word;   // readback mux
  logic           [31:0] wr_merge;  // new bytes over old value
  ctl_word_u             wr_word;   // write data seen as command
  ctl_word_u             sts_word;  // status seen on read
  logic                  wr_ctl;
  logic                  cmd_clr;
  logic                  cmd_arm;

  // sequencer
  logic                  acq;
  logic                  trg;
  logic           [31:0] dly_cnt;
  logic                  dly_zero;
  logic                  trg_mux;
  logic                  std_cap;

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wr_mask[8*i +: 8] = {8{sys_sel[i]}};
    end
  end

  assign wr_word = sys_wdata & wr_mask;
  assign wr_ctl  = sys_wen && (sys_addr[5:0] == REG_CTL);
  assign cmd_clr = wr_ctl && wr_word.cmd.clear;
  assign cmd_arm = wr_ctl && wr_word.cmd.arm;
  assign trg_swo = wr_ctl && wr_word.cmd.swtrg;  // same cycle as the write

  always_comb begin
    sts_word         = '0;
    sts_word.sts.acq = acq;
    sts_word.sts.trg = trg;
  end

  // readback, zero extended to 32 bits
  always_comb begin
    case (sys_addr[5:0])
      REG_CTL: rd_word = sts_word;
      REG_AVG: rd_word = {31'b0, cfg_avg};
      REG_DEC: rd_word = {{(32-DWC){1'b0}}, cfg_dec};
      REG_SHR: rd_word = {{(32-DWS){1'b0}}, cfg_shr};
      REG_LVL: rd_word = {{(32-DWI){1'b0}}, cfg_lvl};
      REG_HST: rd_word = {{(32-DWI){1'b0}}, cfg_hst};
      REG_SEL: rd_word = {{(32-TWS){1'b0}}, cfg_sel};
      REG_DLY: rd_word = cfg_dly;
      default: rd_word = '0;  // unmapped
    endcase
  end

  assign wr_merge = (sys_wdata & wr_mask) | (rd_word & ~wr_mask);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_sel <= '0;
      cfg_dly <= '0;
    end else if (sys_wen) begin
      case (sys_addr[5:0])
        REG_AVG: cfg_avg <= wr_merge[0];
        REG_DEC: cfg_dec <= wr_merge[DWC-1:0];
        REG_SHR: cfg_shr <= wr_merge[DWS-1:0];
        REG_LVL: cfg_lvl <= wr_merge[DWI-1:0];
        REG_HST: cfg_hst <= wr_merge[DWI-1:0];
        REG_SEL: cfg_sel <= wr_merge[TWS-1:0];
        REG_DLY: cfg_dly <= wr_merge;
        default: ;  // control word handled as commands
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_ack <= 1'b0;
      sys_err <= 1'b0;
    end else begin
      sys_ack <= sys_wen || sys_ren;  // one cycle latency
      sys_err <= 1'b0;                // no error source
    end
  end

  always_ff @(posedge clk) begin
    if (sys_ren) begin
      sys_rdata <= rd_word;
    end
  end

  // to datapath
  assign cfg.clr = cmd_clr;
  assign cfg.avg = cfg_avg;
  assign cfg.dec = cfg_dec;
  assign cfg.shr = cfg_shr;
  assign cfg.lvl = cfg_lvl;
  assign cfg.hst = cfg_hst;

  //////////////////////////////////////////////////
  // acquire / trigger / delay
  //////////////////////////////////////////////////

  assign trg_mux  = (cfg_sel < TWA) ? trg_ext[cfg_sel] : 1'b0;  // out of range selects none
  assign dly_zero = (dly_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acq     <= 1'b0;
      trg     <= 1'b0;
      dly_cnt <= '0;
    end else if (cmd_clr) begin
      acq <= 1'b0;  // abort
      trg <= 1'b0;
    end else begin
      if (acq && !trg && trg_mux) begin
        trg     <= 1'b1;
        dly_cnt <= cfg_dly;
      end else if (trg && std_cap) begin
        if (dly_zero) begin
          trg <= 1'b0;  // last sample leaves now
          acq <= 1'b0;
        end else begin
          dly_cnt <= dly_cnt - 32'd1;
        end
      end
      if (cmd_arm) begin
        acq <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////

  // drop everything while idle, else one deep pipeline
  assign std_rdy = !acq || !sto_vld || sto_rdy;
  assign std_cap = std_vld && std_rdy && acq;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end else if (std_cap) begin
      sto_vld <= 1'b1;
      sto_lst <= trg && dly_zero;  // final post trigger sample
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (std_cap) begin
      sto_dat <= std_dat;
    end
  end

  a_lst_vld: assert property (@(posedge clk) disable iff (!rstn) sto_lst |-> sto_vld);
  a_trg_acq: assert property (@(posedge clk) disable iff (!rstn) trg |-> acq);

endmodule : scope_ctrl

// File: rtl/scope_dec_avg.sv
//////////////////////////////////////////////////
// decimator
// passes one sample per group, optionally the
// shifted group sum instead of the last sample
//////////////////////////////////////////////////

`timescale 1ns/100ps

module scope_dec_avg #(
  int unsigned DWI = 14,  // sample width
  int unsigned DWC = 17,  // group counter width
  int unsigned DWS = 4    // shift width
)(
  input  logic                  clk,
  input  logic                  rstn,
  // config
  scope_cfg_if.decim            cfg,
  // input stream
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // decimated stream
  output logic signed [DWI-1:0] sto_dat,
  output logic                  sto_vld,
  input  logic                  sto_rdy
);

  // room for 2**DWC full scale samples
  localparam int unsigned DWA = DWI + DWC;

  logic        [DWC-1:0] cnt;      // samples taken in group
  logic signed [DWA-1:0] sum;      // group sum so far
  logic signed [DWA-1:0] sum_nxt;  // including current sample
  logic signed [DWA-1:0] sum_shr;
  logic                  sti_acc;
  logic                  grp_end;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // input stalls while output is held
  assign sti_rdy = !sto_vld || sto_rdy;
  assign sti_acc = sti_vld && sti_rdy;

  // >= so a smaller dec written mid group still ends it
  assign grp_end = (cnt >= cfg.dec);

  assign sum_nxt = sum + DWA'(sti_dat);  // sign extended
  assign sum_shr = sum_nxt >>> cfg.shr[DWS-1:0];

  //////////////////////////////////////////////////
  // group counter and accumulator
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
      sum <= '0;
    end else if (cfg.clr) begin
      cnt <= '0;  // flush partial group
      sum <= '0;
    end else if (sti_acc) begin
      if (grp_end) begin
        cnt <= '0;
        sum <= '0;
      end else begin
        cnt <= cnt + 1'b1;
        sum <= sum_nxt;
      end
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
    end else if (sti_acc && grp_end && !cfg.clr) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sti_acc && grp_end && !cfg.clr) begin
      sto_dat <= cfg.avg ? sum_shr[DWI-1:0] : sti_dat;  // truncated average or last sample
    end
  end

  a_dat_hold: assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy |=> sto_vld && $stable(sto_dat));

endmodule : scope_dec_avg

// File: rtl/scope_edge.sv
//////////////////////////////////////////////////
// level crossing detector
// schmitt style edge triggers on the raw stream
//////////////////////////////////////////////////

`timescale 1ns/100ps

module scope_edge #(
  int unsigned DWI = 14  // sample width
)(
  input  logic                  clk,
  input  logic                  rstn,
  // config
  scope_cfg_if.edge_det         cfg,
  // observed stream
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  input  logic                  sti_rdy,
  // triggers
  output logic                  trg_pdg,  // rising crossing
  output logic                  trg_ndg   // falling crossing
);

  // two guard bits so lvl +/- hst never wraps
  localparam int unsigned DWT = DWI + 2;

  logic signed [DWT-1:0] smp;
  logic signed [DWT-1:0] lvl_x;
  logic signed [DWT-1:0] hst_x;
  logic signed [DWT-1:0] thr_lo;  // arm level for rising edge
  logic signed [DWT-1:0] thr_hi;  // arm level for falling edge
  logic                  sti_acc;
  logic                  pos_arm;
  logic                  neg_arm;

  assign sti_acc = sti_vld && sti_rdy;  // only real transfers count

  assign smp    = DWT'(sti_dat);  // sign extended
  assign lvl_x  = DWT'(cfg.lvl);
  assign hst_x  = DWT'(cfg.hst);  // zero extended
  assign thr_lo = lvl_x - hst_x;
  assign thr_hi = lvl_x + hst_x;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pos_arm <= 1'b0;
      neg_arm <= 1'b0;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= 1'b0;  // pulses
      trg_ndg <= 1'b0;
      if (sti_acc) begin
        // rising side
        if (smp < thr_lo) begin
          pos_arm <= 1'b1;
        end else if (pos_arm && smp >= lvl_x) begin
          pos_arm <= 1'b0;
          trg_pdg <= 1'b1;
        end
        // falling side, mirror
        if (smp > thr_hi) begin
          neg_arm <= 1'b1;
        end else if (neg_arm && smp <= lvl_x) begin
          neg_arm <= 1'b0;
          trg_ndg <= 1'b1;
        end
      end
    end
  end

  a_one_edge: assert property (@(posedge clk) disable iff (!rstn) !(trg_pdg && trg_ndg));

endmodule : scope_edge

// File: rtl/scope_pkg.sv
//////////////////////////////////////////////////
// scope package
// register map and control/status word layout
//////////////////////////////////////////////////

package scope_pkg;

  //////////////////////////////////////////////////
  // register offsets
  //////////////////////////////////////////////////

  // decoded from the low 6 address bits only
  localparam logic [5:0] REG_CTL = 6'h00;  // control on write, status on read
  localparam logic [5:0] REG_AVG = 6'h08;  // averaging enable
  localparam logic [5:0] REG_DEC = 6'h0C;  // decimation factor minus one
  localparam logic [5:0] REG_SHR = 6'h10;  // shift right after averaging
  localparam logic [5:0] REG_LVL = 6'h14;  // edge level
  localparam logic [5:0] REG_HST = 6'h18;  // edge hysteresis
  localparam logic [5:0] REG_SEL = 6'h1C;  // external trigger select
  localparam logic [5:0] REG_DLY = 6'h20;  // post trigger delay

  //////////////////////////////////////////////////
  // control/status word
  //////////////////////////////////////////////////

  // write view, each set bit is a one-shot command
  typedef struct packed {
    logic [28:0] unused;  // ignored
    logic        arm;     // start acquisition
    logic        swtrg;   // software trigger pulse
    logic        clear;   // abort run, flush decimator group
  } ctl_cmd_t;

  // read view
  typedef struct packed {
    logic [28:0] zero;  // reads 0
    logic        acq;   // acquisition running
    logic        trg;   // trigger seen, delay counting
    logic        rsv;   // reads 0
  } ctl_sts_t;

  // same 32 bits, decoded by direction of access
  typedef union packed {
    ctl_cmd_t cmd;
    ctl_sts_t sts;
  } ctl_word_u;

endpackage : scope_pkg

// File: rtl/scope_top.sv
//////////////////////////////////////////////////
// scope capture front end
// decimator, edge trigger and capture control
//////////////////////////////////////////////////

`timescale 1ns/100ps

module scope_top #(
  int unsigned DWI = 14,  // sample width
  int unsigned DWC = 17,  // decimation counter width
  int unsigned DWS = 4,   // shift width
  int unsigned TWA = 4    // external trigger lines
)(
  input  logic                  clk,
  input  logic                  rstn,
  // ADC stream
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // captured stream
  output logic signed [DWI-1:0] sto_dat,
  output logic                  sto_lst,
  output logic                  sto_vld,
  input  logic                  sto_rdy,
  // triggers
  input  logic        [TWA-1:0] trg_ext,
  output logic                  trg_swo,
  output logic            [1:0] trg_out,  // [0] rising, [1] falling
  // system bus
  input  logic           [31:0] sys_addr,
  input  logic           [31:0] sys_wdata,
  input  logic            [3:0] sys_sel,
  input  logic                  sys_wen,
  input  logic                  sys_ren,
  output logic           [31:0] sys_rdata,
  output logic                  sys_err,
  output logic                  sys_ack
);

  localparam int unsigned TWS = (TWA > 1) ? $clog2(TWA) : 1;

  // decimated stream
  logic signed [DWI-1:0] std_dat;
  logic                  std_vld;
  logic                  std_rdy;

  scope_cfg_if #(.DWI(DWI), .DWC(DWC), .DWS(DWS)) cfg ();

  scope_ctrl #(
    .DWI(DWI), .DWC(DWC), .DWS(DWS), .TWA(TWA), .TWS(TWS)
  ) ctrl_inst (
    .clk(clk), .rstn(rstn),
    .sys_addr(sys_addr), .sys_wdata(sys_wdata), .sys_sel(sys_sel),
    .sys_wen(sys_wen), .sys_ren(sys_ren),
    .sys_rdata(sys_rdata), .sys_err(sys_err), .sys_ack(sys_ack),
    .trg_ext(trg_ext), .trg_swo(trg_swo),
    .cfg(cfg.ctrl),
    .std_dat(std_dat), .std_vld(std_vld), .std_rdy(std_rdy),
    .sto_dat(sto_dat), .sto_vld(sto_vld), .sto_lst(sto_lst), .sto_rdy(sto_rdy)
  );

  scope_dec_avg #(.DWI(DWI), .DWC(DWC), .DWS(DWS)) dec_avg_inst (
    .clk(clk), .rstn(rstn),
    .cfg(cfg.decim),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .sto_dat(std_dat), .sto_vld(std_vld), .sto_rdy(std_rdy)
  );

  // watches the raw input transfers
  scope_edge #(.DWI(DWI)) edge_inst (
    .clk(clk), .rstn(rstn),
    .cfg(cfg.edge_det),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .trg_pdg(trg_out[0]), .trg_ndg(trg_out[1])
  );

endmodule : scope_top

// File: tb.f
rtl/scope_pkg.sv
rtl/scope_cfg_if.sv
rtl/scope_ctrl.sv
rtl/scope_dec_avg.sv
rtl/scope_edge.sv
rtl/scope_top.sv
verification/tb_clk_gen.sv
verification/tb_scope.sv

// File: verification/tb_clk_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset
// 20 ns clock, reset low for the first 5 edges
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clk_gen #(
  int unsigned HALF_NS    = 10,  // half period
  int unsigned RST_CYCLES = 5    // edges with rstn low
)(
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rstn <= 1'b1;  // released on an edge
  end

endmodule : tb_clk_gen

// File: verification/tb_scope.sv
//////////////////////////////////////////////////
// scope capture testbench
// random streams and bus traffic against a model
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_scope
  import scope_pkg::*;
();

  localparam int unsigned DWI = 14;
  localparam int unsigned DWC = 17;
  localparam int unsigned DWS = 4;
  localparam int unsigned TWA = 4;
  localparam int unsigned TWS = $clog2(TWA);
  localparam int          CLK_NS = 20;

  // test lengths, also sizing the watchdog
  localparam int N_DEC  = 4;    // rounds per decimation test
  localparam int L_DEC  = 60;   // samples per round
  localparam int N_EDGE = 3;
  localparam int L_EDGE = 150;
  localparam int N_CAP  = 4;
  localparam int L_CAP  = 60;   // upper bound per capture round
  localparam int L_CLR  = 60;
  localparam int N_SMP  = 2*N_DEC*L_DEC + N_EDGE*L_EDGE + N_CAP*L_CAP + L_CLR;
  localparam int N_BUS  = 200;  // bound on bus accesses
  localparam int LIMIT_CYC = 40*N_SMP + 16*N_BUS + 200;

  logic                  clk;
  logic                  rstn;
  logic signed [DWI-1:0] sti_dat;
  logic                  sti_vld;
  logic                  sti_rdy;
  logic signed [DWI-1:0] sto_dat;
  logic                  sto_lst;
  logic                  sto_vld;
  logic                  sto_rdy;
  logic        [TWA-1:0] trg_ext;
  logic                  trg_swo;
  logic            [1:0] trg_out;
  logic           [31:0] sys_addr;
  logic           [31:0] sys_wdata;
  logic            [3:0] sys_sel;
  logic                  sys_wen;
  logic                  sys_ren;
  logic           [31:0] sys_rdata;
  logic                  sys_err;
  logic                  sys_ack;

  integer seed;
  string  test_name;
  int     walk;  // random walk of the input

  // register shadows
  logic                  m_avg;
  logic        [DWC-1:0] m_dec;
  logic        [DWS-1:0] m_shr;
  int                    m_lvl;  // sign extended
  int                    m_hst;
  logic        [TWS-1:0] m_sel;
  logic           [31:0] m_dly;

  // model state
  int                    m_cnt;   // samples in current group
  longint                m_sum;
  logic                  m_acq;
  logic                  m_trg;
  logic           [31:0] m_left;  // post trigger samples still to go
  logic                  m_pos;   // rising edge armed
  logic                  m_neg;   // falling edge armed
  logic                  exp_pdg;
  logic                  exp_ndg;
  logic                  exp_swo;  // software trigger write on the bus
  logic signed [DWI-1:0] exp_dat [$];
  logic                  exp_lst [$];

  tb_clk_gen clk_gen_inst (.clk(clk), .rstn(rstn));

  scope_top #(.DWI(DWI), .DWC(DWC), .DWS(DWS), .TWA(TWA)) scope_top_inst (.*);

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error in %s", test_name);
  endtask

  task automatic check_sample(input string what, input logic signed [DWI-1:0] exp,
                              input logic signed [DWI-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(input string what, input ctl_word_u exp, input ctl_word_u act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected acq=%0b trg=%0b (0x%08h), actual acq=%0b trg=%0b (0x%08h)",
               test_name, what, exp.sts.acq, exp.sts.trg, exp, act.sts.acq, act.sts.trg, act);
      stop_run();
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %0b, actual %0b", test_name, what, exp, act);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////
  // model
  //////////////////////////////////////////////////

  // decimated sample reaching the control stage
  task automatic push_capture(input logic signed [DWI-1:0] s);
    if (m_acq) begin
      exp_dat.push_back(s);
      exp_lst.push_back(m_trg && m_left == 0);
      if (m_trg) begin
        if (m_left == 0) begin
          m_acq = 1'b0;  // run complete
          m_trg = 1'b0;
        end else begin
          m_left--;
        end
      end
    end
  endtask

  // one accepted input sample
  task automatic predict_input(input logic signed [DWI-1:0] s);
    logic signed [DWI-1:0] avg_out;
    // hysteresis, rising side
    if (s < m_lvl - m_hst) begin
      m_pos = 1'b1;
    end else if (m_pos && s >= m_lvl) begin
      m_pos   = 1'b0;
      exp_pdg = 1'b1;
    end
    // falling side
    if (s > m_lvl + m_hst) begin
      m_neg = 1'b1;
    end else if (m_neg && s <= m_lvl) begin
      m_neg   = 1'b0;
      exp_ndg = 1'b1;
    end
    // group of dec+1 samples
    m_sum += s;
    if (m_cnt >= m_dec) begin
      avg_out = m_sum >>> m_shr;  // truncated to sample width
      push_capture(m_avg ? avg_out : s);
      m_cnt = 0;
      m_sum = 0;
    end else begin
      m_cnt++;
    end
  endtask

  // checks and prediction, sampled mid cycle
  always @(negedge clk) begin
    if (!rstn) begin
      m_pos   = 1'b0;
      m_neg   = 1'b0;
      exp_pdg = 1'b0;
      exp_ndg = 1'b0;
    end else begin
      check_flag("sys_err", 1'b0, sys_err);
      check_flag("trg_swo", exp_swo, trg_swo);
      check_flag("trg_out rising", exp_pdg, trg_out[0]);
      check_flag("trg_out falling", exp_ndg, trg_out[1]);
      exp_pdg = 1'b0;
      exp_ndg = 1'b0;
      if (sto_vld && sto_rdy) begin
        if (exp_dat.size() == 0) begin
          $display("output sample %0d appeared where no capture was expected", sto_dat);
          stop_run();
        end else begin
          check_sample("sto_dat", exp_dat.pop_front(), sto_dat);
          check_flag("sto_lst", exp_lst.pop_front(), sto_lst);
        end
      end
      if (sti_vld && sti_rdy) begin
        predict_input(sti_dat);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  // one clock, output side ready at random
  task automatic tick();
    @(posedge clk);
    sto_rdy <= (($random(seed) & 7) < 5);
  endtask

  function automatic int next_walk(input int w);
    int v;
    if (($random(seed) & 31) == 0) begin
      v = $random(seed) % 8192;  // occasional jump
    end else begin
      v = w + $random(seed) % 400;
    end
    if (v > 8191) begin
      v = 8191;
    end
    if (v < -8192) begin
      v = -8192;
    end
    return v;
  endfunction

  task automatic bus_access(input logic wr, input logic [5:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    tick();
    sys_addr  <= {26'b0, addr};
    sys_wdata <= wdata;
    sys_wen   <= wr;
    sys_ren   <= !wr;
    exp_swo    = wr && (addr == REG_CTL) && wdata[1];  // swtrg command in this cycle
    n = 0;
    do begin
      tick();
      sys_wen <= 1'b0;
      sys_ren <= 1'b0;
      exp_swo  = 1'b0;
      n++;
    end while (!sys_ack && n < 4);
    if (!sys_ack || n != 2) begin
      $display("bus access to 0x%02h was not acknowledged one cycle after the request", addr);
      stop_run();
    end
    rdata = sys_rdata;
  endtask

  task automatic bus_write(input logic [5:0] addr, input logic [31:0] data);
    logic [31:0] rd_dummy;
    ctl_word_u   w;
    bus_access(1'b1, addr, data, rd_dummy);
    w = data;
    case (addr)
      REG_CTL: begin
        if (w.cmd.clear) begin
          m_acq = 1'b0;
          m_trg = 1'b0;
          m_cnt = 0;  // group flushed
          m_sum = 0;
        end else if (w.cmd.arm) begin
          m_acq = 1'b1;
        end
      end
      REG_AVG: m_avg = data[0];
      REG_DEC: m_dec = data[DWC-1:0];
      REG_SHR: m_shr = data[DWS-1:0];
      REG_LVL: m_lvl = $signed(data[DWI-1:0]);
      REG_HST: m_hst = data[DWI-1:0];
      REG_SEL: m_sel = data[TWS-1:0];
      REG_DLY: m_dly = data;
      default: ;
    endcase
  endtask

  task automatic bus_read(input logic [5:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic expect_status(input string what);
    logic [31:0] raw;
    ctl_word_u   exp;
    ctl_word_u   act;
    bus_read(REG_CTL, raw);
    act         = raw;
    exp         = '0;
    exp.sts.acq = m_acq;
    exp.sts.trg = m_trg;
    check_status(what, exp, act);
  endtask

  // n accepted input samples, random gaps
  task automatic stream(input int n);
    int sent;
    sent = 0;
    while (sent < n) begin
      tick();
      if (sti_vld && sti_rdy) begin
        sent++;
      end
      trg_ext <= TWA'($random(seed)) & ~(TWA'(1) << m_sel);  // unselected lines only
      if (!sti_vld || sti_rdy) begin
        if (sent < n && ($random(seed) & 3) != 0) begin
          walk = next_walk(walk);
          sti_dat <= DWI'(walk);
          sti_vld <= 1'b1;
        end else begin
          sti_vld <= 1'b0;
        end
      end
    end
    trg_ext <= '0;
  endtask

  // wait until every predicted sample has left
  task automatic drain();
    int n;
    n = 0;
    while (exp_dat.size() != 0 && n < 400) begin
      tick();
      n++;
    end
    if (exp_dat.size() != 0) begin
      $display("%0d expected output samples never left the DUT", exp_dat.size());
      stop_run();
    end
    repeat (4) tick();  // dropped samples flush
  endtask

  task automatic pulse_trigger();
    tick();
    trg_ext <= TWA'(1) << m_sel;
    tick();
    trg_ext <= '0;
    if (m_acq && !m_trg) begin
      m_trg  = 1'b1;
      m_left = m_dly;
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic readback_regs();
    logic  [5:0] regs  [7] = '{REG_AVG, REG_DEC, REG_SHR, REG_LVL, REG_HST, REG_SEL, REG_DLY};
    logic [31:0] masks [7] = '{32'h1, (32'd1 << DWC) - 1, (32'd1 << DWS) - 1,
                               (32'd1 << DWI) - 1, (32'd1 << DWI) - 1, (32'd1 << TWS) - 1,
                               32'hFFFF_FFFF};
    logic  [5:0] holes [4] = '{6'h04, 6'h24, 6'h2C, 6'h3C};
    logic [31:0] wval;
    logic [31:0] rval;
    test_name = "readback";
    for (int i = 0; i < 7; i++) begin
      wval = $random(seed);
      bus_write(regs[i], wval);
      bus_read(regs[i], rval);
      check_word($sformatf("reg 0x%02h", regs[i]), wval & masks[i], rval);
    end
    for (int i = 0; i < 4; i++) begin
      bus_write(holes[i], $random(seed));
      bus_read(holes[i], rval);
      check_word($sformatf("unmapped 0x%02h", holes[i]), 32'h0, rval);
    end
  endtask

  task automatic decimate_rounds(input logic avg);
    test_name = avg ? "averaging" : "decimation";
    for (int r = 0; r < N_DEC; r++) begin
      bus_write(REG_AVG, avg);
      bus_write(REG_DEC, $random(seed) & 7);
      bus_write(REG_SHR, avg ? ($random(seed) & 15) : 0);
      bus_write(REG_CTL, 32'h1);  // clear
      bus_write(REG_CTL, 32'h4);  // arm, never triggered
      stream(L_DEC);
      drain();
      bus_write(REG_CTL, 32'h1);
      expect_status("after clear");
    end
  endtask

  task automatic edge_rounds();
    test_name = "edges";
    for (int r = 0; r < N_EDGE; r++) begin
      bus_write(REG_LVL, $random(seed) % 3000);
      bus_write(REG_HST, $random(seed) & 511);
      stream(L_EDGE);  // idle, outputs dropped
      drain();
    end
  endtask

  task automatic capture_rounds();
    int dec;
    int dly;
    test_name = "capture";
    for (int r = 0; r < N_CAP; r++) begin
      dec = $random(seed) & 3;
      dly = {$random(seed)} % 6;
      bus_write(REG_AVG, 32'h0);
      bus_write(REG_DEC, dec);
      bus_write(REG_SEL, {$random(seed)} % TWA);
      bus_write(REG_DLY, dly);
      bus_write(REG_CTL, 32'h1);
      stream(10);  // before arming, must not show up
      drain();
      bus_write(REG_CTL, 32'h4);
      expect_status("armed");
      stream(10);
      drain();
      pulse_trigger();
      expect_status("triggered");
      stream((dly + 3) * (dec + 1));  // more than the run needs
      drain();
      expect_status("after last sample");
      bus_write(REG_CTL, 32'h2);  // software trigger, swo checked by monitor
    end
  endtask

  task automatic clear_mid_capture();
    test_name = "clear";
    bus_write(REG_DEC, {$random(seed)} % 4);
    bus_write(REG_DLY, 20 + {$random(seed)} % 10);
    bus_write(REG_CTL, 32'h1);
    bus_write(REG_CTL, 32'h4);
    stream(8);
    drain();
    pulse_trigger();
    stream(3 * (int'(m_dec) + 1));
    drain();
    expect_status("mid capture");
    bus_write(REG_CTL, 32'h1);
    expect_status("after clear");
    stream(20);
    drain();
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    seed      = 32'h3916;
    walk      = 0;
    test_name = "reset";
    sti_dat   = '0;
    sti_vld   = 1'b0;
    sto_rdy   = 1'b0;
    trg_ext   = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_sel   = 4'hF;  // full words only
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    exp_swo   = 1'b0;
    m_avg     = 1'b0;
    m_dec     = '0;
    m_shr     = '0;
    m_lvl     = 0;
    m_hst     = 0;
    m_sel     = '0;
    m_dly     = '0;
    m_cnt     = 0;
    m_sum     = 0;
    m_acq     = 1'b0;
    m_trg     = 1'b0;
    m_left    = '0;
    wait (rstn === 1'b1);
    tick();

    readback_regs();
    decimate_rounds(1'b0);
    decimate_rounds(1'b1);
    edge_rounds();
    capture_rounds();
    clear_mid_capture();

    test_name = "end";
    drain();
    check_flag("idle sto_vld", 1'b0, sto_vld);
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #(LIMIT_CYC * CLK_NS);
    $display("watchdog expired after %0d cycles, a handshake hung in %s", LIMIT_CYC, test_name);
    $display("TESTS FAILED");
    $fatal(1, "run stopped by watchdog");
  end

endmodule : tb_scope
